// ==== src/eim_rd_cfg.svh ====
`ifndef EIM_RD_CFG_SVH
`define EIM_RD_CFG_SVH

// ========================================
// bus and controller widths
// ========================================
`define EIM_WORD_W      64
`define DDR3_ADR_W      30
`define DDR3_DATA_W     32
`define PKT_CNT_W       5
`define FIFO_CNT_W      7
`define RD_COUNT_W      8

// ========================================
// fixed constants
// ========================================
`define DDR3_CMD_READ   3'b001
`define FETCH_MIN_WORDS 2    // one full pair in the read fifo

`endif

// ==== src/eim_rd_pkg.sv ====
`include "eim_rd_cfg.svh"

package eim_rd_pkg;

   // command latched from the control word
   typedef struct packed {
      logic [`DDR3_ADR_W-1:0] adr;
      logic [`PKT_CNT_W-1:0]  num_pkts;
   } rd_cmd_t;

   // controller read fifo level
   typedef struct packed {
      logic [`FIFO_CNT_W-1:0] count;
      logic                   empty;
      logic                   full;
   } fifo_level_t;

   // controller command fifo level
   typedef struct packed {
      logic empty;
      logic full;
   } cmd_port_level_t;

   // ========================================
   // host status word, msb first
   // ========================================
   typedef struct packed {
      logic [`EIM_WORD_W-`RD_COUNT_W-17:0] zero_hi;
      logic [`RD_COUNT_W-1:0]               readcount;
      logic [1:0]                           zero_mid;
      logic                                 word_ready;
      logic                                 cmd_err;   // sticky
      logic                                 cmd_empty;
      logic                                 cmd_full;
      logic                                 rd_empty;
      logic                                 rd_full;
      logic                                 zero_lo;
      logic [`FIFO_CNT_W-1:0]               fifo_count;
   } rd_status_t;

endpackage

// ==== src/rd_cmd_decode.sv ====
`timescale 1ns/1ps

`include "eim_rd_cfg.svh"

module rd_cmd_decode
   import eim_rd_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_errors,
   input  logic [`EIM_WORD_W-1:0] ctl,
   input  logic                   ctl_stb,
   output rd_cmd_t                cmd,
   output logic                   cmd_go
);

   localparam int PKT_LSB = 32;   // count field position in ctl

   logic [`PKT_CNT_W-1:0] ctl_pkts;
   logic                  ctl_nonzero;

   assign ctl_pkts    = ctl[PKT_LSB +: `PKT_CNT_W];
   assign ctl_nonzero = (ctl_pkts != '0);

   // ========================================
   // command capture
   // ========================================
   always_ff @(posedge clk) begin
      if (ctl_stb) begin
         cmd.adr      <= ctl[`DDR3_ADR_W-1:0];
         cmd.num_pkts <= ctl_pkts;
      end
   end

   // zero count starts nothing
   always_ff @(posedge clk) begin
      if (reset_errors) begin
         cmd_go <= 1'b0;
      end else begin
         cmd_go <= ctl_stb & ctl_nonzero;
      end
   end

   // single cycle go pulse
   a_go_pulse : assert property (
      @(posedge clk) disable iff (reset_errors)
      cmd_go |=> !cmd_go
   ) else $error("cmd_go held high for more than one cycle");

endmodule

// ==== src/rd_cmd_issue.sv ====
`timescale 1ns/1ps

`include "eim_rd_cfg.svh"

module rd_cmd_issue
   import eim_rd_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_errors,
   input  rd_cmd_t                cmd,
   input  logic                   cmd_go,
   input  cmd_port_level_t        cmd_level,
   output logic [2:0]             ddr3_rd_cmd,
   output logic [`PKT_CNT_W:0]    ddr3_rd_bl,
   output logic [`DDR3_ADR_W-1:0] ddr3_rd_adr,
   output logic                   ddr3_rd_cmd_en,
   output logic                   cmd_err
);

   // ========================================
   // command port
   // ========================================
   assign ddr3_rd_cmd    = `DDR3_CMD_READ;
   assign ddr3_rd_adr    = {cmd.adr[`DDR3_ADR_W-1:2], 2'b00};   // word aligned
   // two fifo words per packet, bl is length minus one
   assign ddr3_rd_bl     = {cmd.num_pkts, 1'b0} - 1'b1;
   assign ddr3_rd_cmd_en = cmd_go;

   // overflow flag stays until cleared
   always_ff @(posedge clk) begin
      if (reset_errors) begin
         cmd_err <= 1'b0;
      end else if (cmd_go && cmd_level.full) begin
         cmd_err <= 1'b1;
      end
   end

   a_adr_aligned : assert property (
      @(posedge clk) disable iff (reset_errors)
      ddr3_rd_cmd_en |-> (ddr3_rd_adr[1:0] == 2'b00)
   ) else $error("read command issued with unaligned address");

endmodule

// ==== src/rd_burst_fetch.sv ====
`timescale 1ns/1ps

`include "eim_rd_cfg.svh"

module rd_burst_fetch
   import eim_rd_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset_errors,
   input  logic [`PKT_CNT_W-1:0]   num_pkts,
   input  logic                    cmd_go,
   input  fifo_level_t             rd_level,
   input  logic [`DDR3_DATA_W-1:0] ddr3_rd_data,
   output logic                    ddr3_rd_en,
   output logic [`EIM_WORD_W-1:0]  burst_word,
   output logic                    word_ready,
   input  logic                    rd_stb
);

   localparam int CNT_W  = `FIFO_CNT_W;
   localparam int DW     = `DDR3_DATA_W;
   localparam int N_ST   = 6;

   // one-hot state bits
   localparam int S_IDLE  = 0;
   localparam int S_PEND  = 1;
   localparam int S_FETCH = 2;
   localparam int S_LSB   = 3;
   localparam int S_MSB   = 4;
   localparam int S_WAIT  = 5;

   localparam logic [N_ST-1:0] ST_IDLE = N_ST'(1) << S_IDLE;

   logic [N_ST-1:0]            state;
   logic [N_ST-1:0]            state_nxt;
   logic [`PKT_CNT_W-1:0]      outstanding;
   logic [`EIM_WORD_W-1:0]     rd_cache;
   logic                       pair_avail;
   logic                       drain_more;

   // full pair present, no drain pop in flight
   assign pair_avail = (rd_level.count >= CNT_W'(`FETCH_MIN_WORDS)) && !ddr3_rd_en;
   // leftover word beyond the one being popped now
   assign drain_more = (rd_level.count > CNT_W'(ddr3_rd_en));

   // ========================================
   // next state
   // ========================================
   always_comb begin
      state_nxt = ST_IDLE;
      case (1'b1)
         state[S_IDLE]: begin
            if (cmd_go) begin
               state_nxt = N_ST'(1) << S_PEND;
            end
         end
         state[S_PEND]: begin
            if (outstanding == '0) begin
               state_nxt = ST_IDLE;
            end else if (pair_avail) begin
               state_nxt = N_ST'(1) << S_FETCH;
            end else begin
               state_nxt = N_ST'(1) << S_PEND;
            end
         end
         state[S_FETCH]: state_nxt = N_ST'(1) << S_LSB;
         state[S_LSB]:   state_nxt = N_ST'(1) << S_MSB;
         state[S_MSB], state[S_WAIT]: begin
            if (rd_stb) begin
               state_nxt = N_ST'(1) << S_PEND;
            end else begin
               state_nxt = N_ST'(1) << S_WAIT;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   // ========================================
   // control registers
   // ========================================
   always_ff @(posedge clk) begin
      if (reset_errors) begin
         state       <= ST_IDLE;
         outstanding <= '0;
         ddr3_rd_en  <= 1'b0;
      end else begin
         state <= state_nxt;
         if (state[S_IDLE]) begin
            outstanding <= num_pkts;
         end else if (state[S_MSB]) begin
            outstanding <= outstanding - 1'b1;
         end
         // pair pops in lsb and msb, idle drains leftovers
         ddr3_rd_en <= (state[S_IDLE] & drain_more) | state[S_FETCH] | state[S_LSB];
      end
   end

   // pair packing, low word first
   always_ff @(posedge clk) begin
      if (state[S_LSB]) begin
         rd_cache[DW-1:0] <= ddr3_rd_data;
      end
      if (state[S_MSB]) begin
         rd_cache[2*DW-1:DW] <= ddr3_rd_data;
      end
   end

   // high word shown straight from the fifo head while it is popped
   assign burst_word = {(state[S_MSB] ? ddr3_rd_data : rd_cache[2*DW-1:DW]),
                        rd_cache[DW-1:0]};
   assign word_ready = state[S_MSB] | state[S_WAIT];

   a_onehot : assert property (
      @(posedge clk) disable iff (reset_errors)
      $onehot(state)
   ) else $error("fetch state is not one-hot");

   a_no_empty_pop : assert property (
      @(posedge clk) disable iff (reset_errors)
      ddr3_rd_en |-> !rd_level.empty
   ) else $error("read fifo popped while empty");

endmodule

// ==== src/rd_host_status.sv ====
`timescale 1ns/1ps

`include "eim_rd_cfg.svh"

module rd_host_status
   import eim_rd_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_errors,
   input  logic                   ctl_stb,
   input  logic                   rd_stb,
   input  logic [`EIM_WORD_W-1:0] burst_word,
   input  logic                   word_ready,
   input  logic                   cmd_err,
   input  fifo_level_t            rd_level,
   input  cmd_port_level_t        cmd_level,
   output logic [`EIM_WORD_W-1:0] burst_rd,
   output rd_status_t             status
);

   logic [`RD_COUNT_W-1:0] readcount;

   // ========================================
   // host read counter
   // ========================================
   always_ff @(posedge clk) begin
      if (reset_errors) begin
         readcount <= '0;
      end else if (ctl_stb) begin
         readcount <= '0;   // new burst
      end else if (rd_stb) begin
         readcount <= readcount + 1'b1;
      end
   end

   assign burst_rd = burst_word;

   // status word assembly
   always_comb begin
      status            = '0;
      status.fifo_count = rd_level.count;
      status.rd_full    = rd_level.full;
      status.rd_empty   = rd_level.empty;
      status.cmd_full   = cmd_level.full;
      status.cmd_empty  = cmd_level.empty;
      status.cmd_err    = cmd_err;
      status.word_ready = word_ready;   // for polling hosts
      status.readcount  = readcount;
   end

endmodule

// ==== src/ddr3_eim_rd_top.sv ====
`timescale 1ns/1ps

`include "eim_rd_cfg.svh"

module ddr3_eim_rd_top
   import eim_rd_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset_errors,
   // host bus
   input  logic [`EIM_WORD_W-1:0]  ctl,
   input  logic                    ctl_stb,
   input  logic                    rd_stb,
   output logic [`EIM_WORD_W-1:0]  burst_rd,
   output logic [`EIM_WORD_W-1:0]  status,
   // controller read command port
   output logic [2:0]              ddr3_rd_cmd,
   output logic [`PKT_CNT_W:0]     ddr3_rd_bl,
   output logic [`DDR3_ADR_W-1:0]  ddr3_rd_adr,
   output logic                    ddr3_rd_cmd_en,
   input  logic                    ddr3_rd_cmd_empty,
   input  logic                    ddr3_rd_cmd_full,
   // controller read data fifo
   input  logic [`DDR3_DATA_W-1:0] ddr3_rd_data,
   input  logic [`FIFO_CNT_W-1:0]  ddr3_rd_count,
   input  logic                    ddr3_rd_empty,
   input  logic                    ddr3_rd_full,
   output logic                    ddr3_rd_en
);

   rd_cmd_t                cmd;
   logic                   cmd_go;
   logic                   cmd_err;
   logic                   word_ready;
   logic [`EIM_WORD_W-1:0] burst_word;
   fifo_level_t            rd_level;
   cmd_port_level_t        cmd_level;

   // ========================================
   // level bundles
   // ========================================
   assign rd_level  = '{count: ddr3_rd_count, empty: ddr3_rd_empty, full: ddr3_rd_full};
   assign cmd_level = '{empty: ddr3_rd_cmd_empty, full: ddr3_rd_cmd_full};

   rd_cmd_decode u_rd_cmd_decode (
      .clk(clk), .reset_errors(reset_errors),
      .ctl(ctl), .ctl_stb(ctl_stb),
      .cmd(cmd), .cmd_go(cmd_go)
   );

   rd_cmd_issue u_rd_cmd_issue (
      .clk(clk), .reset_errors(reset_errors),
      .cmd(cmd), .cmd_go(cmd_go), .cmd_level(cmd_level),
      .ddr3_rd_cmd(ddr3_rd_cmd), .ddr3_rd_bl(ddr3_rd_bl),
      .ddr3_rd_adr(ddr3_rd_adr), .ddr3_rd_cmd_en(ddr3_rd_cmd_en),
      .cmd_err(cmd_err)
   );

   rd_burst_fetch u_rd_burst_fetch (
      .clk(clk), .reset_errors(reset_errors),
      .num_pkts(cmd.num_pkts), .cmd_go(cmd_go),
      .rd_level(rd_level), .ddr3_rd_data(ddr3_rd_data),
      .ddr3_rd_en(ddr3_rd_en), .burst_word(burst_word),
      .word_ready(word_ready), .rd_stb(rd_stb)
   );

   rd_host_status u_rd_host_status (
      .clk(clk), .reset_errors(reset_errors),
      .ctl_stb(ctl_stb), .rd_stb(rd_stb),
      .burst_word(burst_word), .word_ready(word_ready), .cmd_err(cmd_err),
      .rd_level(rd_level), .cmd_level(cmd_level),
      .burst_rd(burst_rd), .status(status)
   );

endmodule

// ==== sim/mcb_rd_port_model.sv ====
`timescale 1ns/1ps

`include "eim_rd_cfg.svh"

module mcb_rd_port_model (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    force_full,
   // command port
   input  logic                    cmd_en,
   input  logic [`PKT_CNT_W:0]     cmd_bl,
   input  logic [`DDR3_ADR_W-1:0]  cmd_adr,
   output logic                    cmd_empty,
   output logic                    cmd_full,
   // read data fifo, first word fall through
   input  logic                    rd_en,
   output logic [`DDR3_DATA_W-1:0] rd_data,
   output logic [`FIFO_CNT_W-1:0]  rd_count,
   output logic                    rd_empty,
   output logic                    rd_full
);

   localparam int DEPTH = 64;
   localparam int CQ_DEPTH = 4;

   logic [`DDR3_DATA_W-1:0] mem [DEPTH];
   logic [5:0]              wr_ptr;
   logic [5:0]              rd_ptr;
   int                      dat_cnt;

   logic [`DDR3_ADR_W-1:0]  cq_adr [CQ_DEPTH];
   logic [`PKT_CNT_W:0]     cq_bl [CQ_DEPTH];
   logic [1:0]              cq_wp;
   logic [1:0]              cq_rp;
   int                      cmd_cnt;

   logic                    busy;
   logic [`DDR3_ADR_W-1:0]  cur_adr;
   logic [`PKT_CNT_W:0]     cur_bl;
   logic [`PKT_CNT_W:0]     word_k;
   int                      delay;

   assign cmd_empty = (cmd_cnt == 0);
   assign cmd_full  = force_full || (cmd_cnt >= CQ_DEPTH);
   assign rd_data   = mem[rd_ptr];
   assign rd_count  = dat_cnt[`FIFO_CNT_W-1:0];
   assign rd_empty  = (dat_cnt == 0);
   assign rd_full   = (dat_cnt >= DEPTH);

   always @(posedge clk) begin
      int n_cmd;
      int n_dat;
      if (rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         dat_cnt <= 0;
         cq_wp   <= '0;
         cq_rp   <= '0;
         cmd_cnt <= 0;
         busy    <= 1'b0;
      end else begin
         n_cmd = cmd_cnt;
         n_dat = dat_cnt;
         if (rd_en && dat_cnt != 0) begin
            rd_ptr <= rd_ptr + 1'b1;
            n_dat = n_dat - 1;
         end
         if (busy) begin
            if (delay != 0) begin
               delay <= delay - 1;
            end else if ($urandom_range(1, 0) == 1 && dat_cnt < DEPTH) begin
               mem[wr_ptr] <= {2'b00, cur_adr} + word_k;   // word k of burst
               wr_ptr <= wr_ptr + 1'b1;
               n_dat = n_dat + 1;
               if (word_k == cur_bl) begin
                  busy <= 1'b0;
               end else begin
                  word_k <= word_k + 1'b1;
               end
            end
         end else if (cmd_cnt != 0) begin
            busy    <= 1'b1;
            cur_adr <= cq_adr[cq_rp];
            cur_bl  <= cq_bl[cq_rp];
            word_k  <= '0;
            delay   <= $urandom_range(10, 1);
            cq_rp   <= cq_rp + 1'b1;
            n_cmd = n_cmd - 1;
         end
         if (cmd_en && !cmd_full) begin
            cq_adr[cq_wp] <= {cmd_adr[`DDR3_ADR_W-1:2], 2'b00};
            cq_bl[cq_wp]  <= cmd_bl;
            cq_wp <= cq_wp + 1'b1;
            n_cmd = n_cmd + 1;
         end
         cmd_cnt <= n_cmd;
         dat_cnt <= n_dat;
      end
   end

endmodule

// ==== sim/tb_ddr3_eim_rd.sv ====
`timescale 1ns/1ps

`include "eim_rd_cfg.svh"

module tb_ddr3_eim_rd
   import eim_rd_pkg::*;
();

   localparam int NB = 20;

   logic                    clk = 1'b0;
   logic                    reset_errors;
   logic [`EIM_WORD_W-1:0]  ctl;
   logic                    ctl_stb;
   logic                    rd_stb;
   logic                    force_full;
   logic [`EIM_WORD_W-1:0]  burst_rd;
   logic [`EIM_WORD_W-1:0]  status;
   logic [2:0]              ddr3_rd_cmd;
   logic [`PKT_CNT_W:0]     ddr3_rd_bl;
   logic [`DDR3_ADR_W-1:0]  ddr3_rd_adr;
   logic                    ddr3_rd_cmd_en;
   logic                    ddr3_rd_cmd_empty;
   logic                    ddr3_rd_cmd_full;
   logic [`DDR3_DATA_W-1:0] ddr3_rd_data;
   logic [`FIFO_CNT_W-1:0]  ddr3_rd_count;
   logic                    ddr3_rd_empty;
   logic                    ddr3_rd_full;
   logic                    ddr3_rd_en;
   rd_status_t              st;

   // expected values from the control word
   logic [`DDR3_ADR_W-1:0]  exp_adr;
   logic [`PKT_CNT_W-1:0]   exp_pkts;
   logic [`RD_COUNT_W-1:0]  exp_reads;
   logic                    exp_err;
   logic                    go_seen;   // command due on the port this cycle
   int                      pair_idx;
   int                      errors = 0;
   int                      total_reads = 0;
   int                      cycles = 0;
   int                      limit = 1000000;
   logic [`DDR3_ADR_W-1:0]  adr_list [NB];
   logic [`PKT_CNT_W-1:0]   pkt_list [NB];

   assign st = status;

   always #50 clk = ~clk;

   ddr3_eim_rd_top u_ddr3_eim_rd_top (.*);

   mcb_rd_port_model u_mcb_rd_port_model (
      .clk(clk), .rst(reset_errors), .force_full(force_full),
      .cmd_en(ddr3_rd_cmd_en), .cmd_bl(ddr3_rd_bl), .cmd_adr(ddr3_rd_adr),
      .cmd_empty(ddr3_rd_cmd_empty), .cmd_full(ddr3_rd_cmd_full),
      .rd_en(ddr3_rd_en), .rd_data(ddr3_rd_data), .rd_count(ddr3_rd_count),
      .rd_empty(ddr3_rd_empty), .rd_full(ddr3_rd_full)
   );

   // pair j holds words 2j and 2j+1 of the burst, low word first
   function automatic logic [63:0] pair_value(input logic [`DDR3_ADR_W-1:0] base, input int j);
      logic [31:0] lo;
      lo = {2'b00, base} + 32'(2 * j);
      return {lo + 32'd1, lo};
   endfunction

   // ========================================
   // reference state
   // ========================================
   always @(posedge clk) begin
      if (reset_errors) begin
         exp_reads <= '0;
         exp_err   <= 1'b0;
         go_seen   <= 1'b0;
         pair_idx  <= 0;
      end else begin
         go_seen <= ctl_stb && ctl[36:32] != 0;
         if (ctl_stb) begin
            exp_adr   <= {ctl[29:2], 2'b00};
            exp_pkts  <= ctl[36:32];
            exp_reads <= '0;
            pair_idx  <= 0;
         end else if (rd_stb) begin
            exp_reads <= exp_reads + 1'b1;
            pair_idx  <= pair_idx + 1;
         end
         if (go_seen && ddr3_rd_cmd_full) begin
            exp_err <= 1'b1;   // sticky
         end
      end
   end

   // ========================================
   // checks
   // ========================================
   a_cmd_op : assert property (@(posedge clk) disable iff (reset_errors)
      ddr3_rd_cmd_en |-> ddr3_rd_cmd == 3'b001)
      else begin
         errors++;
         $display("Fail ddr3_rd_cmd got %h exp %h", $sampled(ddr3_rd_cmd), 3'b001);
      end

   a_cmd_adr : assert property (@(posedge clk) disable iff (reset_errors)
      ddr3_rd_cmd_en |-> ddr3_rd_adr == exp_adr)
      else begin
         errors++;
         $display("Fail ddr3_rd_adr got %h exp %h", $sampled(ddr3_rd_adr), $sampled(exp_adr));
      end

   a_cmd_bl : assert property (@(posedge clk) disable iff (reset_errors)
      ddr3_rd_cmd_en |-> ddr3_rd_bl == 6'({1'b0, exp_pkts} * 2 - 1))
      else begin
         errors++;
         $display("Fail ddr3_rd_bl got %h exp %h", $sampled(ddr3_rd_bl),
                  6'({1'b0, $sampled(exp_pkts)} * 2 - 1));
      end

   a_cmd_en_once : assert property (@(posedge clk) disable iff (reset_errors)
      ctl_stb && ctl[36:32] != 0 |=> ddr3_rd_cmd_en ##1 !ddr3_rd_cmd_en)
      else begin
         errors++;
         $display("read command enable not seen exactly once after the control word");
      end

   a_cmd_en_zero : assert property (@(posedge clk) disable iff (reset_errors)
      ctl_stb && ctl[36:32] == 0 |=> !ddr3_rd_cmd_en)
      else begin
         errors++;
         $display("zero count control word issued a read command");
      end

   a_cmd_en_cause : assert property (@(posedge clk) disable iff (reset_errors)
      ddr3_rd_cmd_en |-> $past(ctl_stb))
      else begin
         errors++;
         $display("read command enable without a control word one cycle before");
      end

   a_burst_data : assert property (@(posedge clk) disable iff (reset_errors)
      rd_stb && st.word_ready |-> burst_rd == pair_value(exp_adr, pair_idx))
      else begin
         errors++;
         $display("Fail burst_rd got %h exp %h", $sampled(burst_rd),
                  pair_value($sampled(exp_adr), $sampled(pair_idx)));
      end

   a_ready_count : assert property (@(posedge clk) disable iff (reset_errors)
      $rose(st.word_ready) |-> pair_idx < int'(exp_pkts))
      else begin
         errors++;
         $display("more words became ready than the burst's packet count");
      end

   a_readcount : assert property (@(posedge clk) disable iff (reset_errors)
      st.readcount == exp_reads)
      else begin
         errors++;
         $display("Fail readcount got %h exp %h", $sampled(st.readcount), $sampled(exp_reads));
      end

   a_cmd_err : assert property (@(posedge clk) disable iff (reset_errors)
      st.cmd_err == exp_err)
      else begin
         errors++;
         $display("Fail cmd_err got %h exp %h", $sampled(st.cmd_err), $sampled(exp_err));
      end

   a_reset_state : assert property (@(posedge clk)
      reset_errors |=> !ddr3_rd_cmd_en && !ddr3_rd_en && !st.word_ready)
      else begin
         errors++;
         $display("command enable, read enable or word ready high after reset");
      end

   a_fifo_fields : assert property (@(posedge clk)
      {st.fifo_count, st.rd_full, st.rd_empty, st.cmd_full, st.cmd_empty} ==
      {ddr3_rd_count, ddr3_rd_full, ddr3_rd_empty, ddr3_rd_cmd_full, ddr3_rd_cmd_empty})
      else begin
         errors++;
         $display("Fail status fifo fields got %h exp %h",
                  $sampled({st.fifo_count, st.rd_full, st.rd_empty, st.cmd_full,
                            st.cmd_empty}),
                  $sampled({ddr3_rd_count, ddr3_rd_full, ddr3_rd_empty,
                            ddr3_rd_cmd_full, ddr3_rd_cmd_empty}));
      end

   // ========================================
   // stimulus
   // ========================================
   task automatic send_ctl(input logic [`DDR3_ADR_W-1:0] adr, input logic [4:0] pkts);
      @(posedge clk);
      ctl     <= {27'h0, pkts, 2'b00, adr};
      ctl_stb <= 1'b1;
      @(posedge clk);
      ctl_stb <= 1'b0;
   endtask

   task automatic read_words(input int n);
      for (int i = 0; i < n; i++) begin
         do @(posedge clk); while (!st.word_ready);
         repeat ($urandom_range(3, 0)) @(posedge clk);   // host gap
         rd_stb <= 1'b1;
         @(posedge clk);
         rd_stb <= 1'b0;
         total_reads++;
      end
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("run timed out after %0d cycles, errors %0d", limit, errors);
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin
      int sum;
      reset_errors = 1'b1;
      ctl          = '0;
      ctl_stb      = 1'b0;
      rd_stb       = 1'b0;
      force_full   = 1'b0;
      void'($urandom(32'h31c4));
      sum = 0;
      for (int i = 0; i < NB; i++) begin
         adr_list[i] = $urandom();
         pkt_list[i] = (i % 9 == 4) ? 5'd0 : 5'($urandom_range(31, 1));
         sum += 40 * pkt_list[i];
      end
      limit = sum + 2000;
      repeat (8) @(posedge clk);
      reset_errors <= 1'b0;

      for (int i = 0; i < NB; i++) begin
         send_ctl(adr_list[i], pkt_list[i]);
         read_words(pkt_list[i]);
         repeat (6) @(posedge clk);
      end

      // overflow, then clear with reset
      force_full <= 1'b1;
      send_ctl(30'h1234_5678, 5'd1);
      repeat (4) @(posedge clk);
      reset_errors <= 1'b1;
      force_full   <= 1'b0;
      repeat (2) @(posedge clk);
      reset_errors <= 1'b0;
      send_ctl(30'h0abc_def0, 5'd3);
      read_words(3);
      repeat (8) @(posedge clk);

      $display("bursts %0d, host reads %0d, errors %0d", NB + 2, total_reads, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+src
src/eim_rd_pkg.sv
src/rd_cmd_decode.sv
src/rd_cmd_issue.sv
src/rd_burst_fetch.sv
src/rd_host_status.sv
src/ddr3_eim_rd_top.sv
sim/mcb_rd_port_model.sv
sim/tb_ddr3_eim_rd.sv
